/* build.f */
source/display_pkg.sv
source/pixel_pkg.sv
source/pixel_write_if.sv
source/raster_timing.sv
source/depth_test.sv
source/frame_buffer.sv
source/scan_out.sv
source/display_top.sv
dv/tb_clock.sv
dv/tb_display.sv

/* dv/tb_display.sv */
`timescale 1ns/100ps

module tb_display;
    import display_pkg::*;
    import pixel_pkg::*;

    localparam int unsigned FRAME_CYCLES   = H_TOTAL * V_TOTAL;
    localparam int unsigned TIMEOUT_CYCLES = 12 * FRAME_CYCLES + 3000;
    localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;

    logic       clk;
    logic       i_rst_n;
    logic       i_clear;
    logic       i_pix_valid;
    pix_addr_t  i_pix_addr;
    color_idx_t i_pix_color;
    depth_t     i_pix_depth;
    logic       o_ready;
    channel_t   o_red;
    channel_t   o_green;
    channel_t   o_blue;
    logic       o_hsync;
    logic       o_vsync;
    logic       o_de;

    logic [31:0] lfsr_state = 32'h25e7_8f11;
    int          cycle_count = 0;
    // Low from reset or a clear until the sweep has been seen to end
    logic        model_ready = 1'b0;
    depth_t      model_depth [FB_DEPTH];
    color_idx_t  model_color [FB_DEPTH];

    tb_clock tb_clock_inst (.o_clk(clk));

    display_top display_top_inst (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_clear     (i_clear),
        .i_pix_valid (i_pix_valid),
        .i_pix_addr  (i_pix_addr),
        .i_pix_color (i_pix_color),
        .i_pix_depth (i_pix_depth),
        .o_ready     (o_ready),
        .o_red       (o_red),
        .o_green     (o_green),
        .o_blue      (o_blue),
        .o_hsync     (o_hsync),
        .o_vsync     (o_vsync),
        .o_de        (o_de)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits       = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Red is the index, green the index reversed, blue the index inverted
    function automatic logic [11:0] expected_rgb(input logic [3:0] idx);
        return {idx, idx[0], idx[1], idx[2], idx[3], ~idx};
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("[FAIL] %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, expected);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic clear_model();
        for (int i = 0; i < FB_DEPTH; i++) begin
            model_depth[i] = DEPTH_CLEAR;
            model_color[i] = COLOR_CLEAR;
        end
    endtask

    task automatic idle();
        @(posedge clk);
        #1;
        i_pix_valid = 1'b0;
        i_clear     = 1'b0;
    endtask

    // Strict-less rule, applied in strobe order
    task automatic send_pixel(input pix_addr_t addr, input color_idx_t color, input depth_t depth);
        @(posedge clk);
        #1;
        check_value("o_ready while sending", o_ready, model_ready);
        i_pix_valid = 1'b1;
        i_pix_addr  = addr;
        i_pix_color = color;
        i_pix_depth = depth;
        if (model_ready && (depth < model_depth[addr])) begin
            model_depth[addr] = depth;
            model_color[addr] = color;
        end
    endtask

    task automatic random_pixel();
        logic [31:0] a;
        logic [31:0] c;
        logic [31:0] d;
        take_bits(8, a);
        take_bits(4, c);
        take_bits(12, d);
        send_pixel(pix_addr_t'(a % FB_DEPTH), c[3:0], d[11:0]);
    endtask

    // Five writes to one address with near depths that rise or fall
    task automatic burst_one_address(input logic increasing);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        take_bits(8, a);
        take_bits(4, b);
        for (int k = 0; k < 5; k++) begin
            take_bits(4, c);
            send_pixel(pix_addr_t'(a % FB_DEPTH), c[3:0],
                       increasing ? depth_t'(b + k) : depth_t'(b + 4 - k));
        end
        idle();
    endtask

    task automatic pulse_clear();
        @(posedge clk);
        #1;
        i_pix_valid = 1'b0;
        i_clear     = 1'b1;
        @(posedge clk);
        #1;
        i_clear = 1'b0;
        model_ready = 1'b0;
        check_value("o_ready low after clear", o_ready, 0);
        clear_model();
    endtask

    task automatic wait_ready();
        int waited;
        waited = 0;
        while (!o_ready && (waited < FB_DEPTH + 4)) begin
            @(posedge clk);
            #1;
            waited++;
        end
        check_value("o_ready high after sweep", o_ready, 1);
        model_ready = 1'b1;
    endtask

    task automatic wait_vsync_start();
        logic prev;
        @(negedge clk);
        prev = o_vsync;
        @(negedge clk);
        while (!(prev && !o_vsync)) begin
            prev = o_vsync;
            @(negedge clk);
        end
    endtask

    // Checks one frame from vsync start to vsync start on falling edges
    task automatic check_frame();
        int          de_cycles;
        int          vs_falls;
        int          vs_low;
        int          hs_falls;
        int          hs_run;
        int          row;
        int          col;
        logic        prev_vs;
        logic        prev_hs;
        pix_addr_t   addr;
        logic [11:0] got;
        de_cycles = 0;
        vs_falls  = 0;
        vs_low    = 0;
        hs_falls  = 0;
        hs_run    = 0;
        prev_vs   = 1'b1;
        prev_hs   = 1'b1;
        wait_vsync_start();
        for (int c = 0; c < FRAME_CYCLES; c++) begin
            if (c > 0) begin
                @(negedge clk);
            end
            got = {o_red, o_green, o_blue};
            if (!o_vsync) begin
                vs_low++;
                if (prev_vs) vs_falls++;
            end
            if (!o_hsync) begin
                hs_run++;
                if (prev_hs) hs_falls++;
            end else if (!prev_hs) begin
                check_value("hsync pulse length", hs_run, H_SYNC);
                hs_run = 0;
            end
            if (o_de && (de_cycles < H_ACTIVE * V_ACTIVE)) begin
                row  = de_cycles / H_ACTIVE;
                col  = de_cycles % H_ACTIVE;
                addr = pix_addr_t'((row >> SCALE_SHIFT) * FB_WIDTH + (col >> SCALE_SHIFT));
                check_value("active pixel colour", got, expected_rgb(model_color[addr]));
            end else if (!o_de) begin
                check_value("colour while o_de is low", got, 0);
            end
            if (o_de) de_cycles++;
            prev_vs = o_vsync;
            prev_hs = o_hsync;
        end
        check_value("o_de cycles per frame", de_cycles, H_ACTIVE * V_ACTIVE);
        check_value("vsync pulses per frame", vs_falls, 1);
        check_value("vsync low cycles", vs_low, V_SYNC * H_TOTAL);
        check_value("hsync pulses per frame", hs_falls, V_TOTAL);
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: no result after %0d clock cycles, the run hung", cycle_count);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        i_rst_n     = 1'b0;
        i_clear     = 1'b0;
        i_pix_valid = 1'b0;
        i_pix_addr  = '0;
        i_pix_color = '0;
        i_pix_depth = '0;
        clear_model();
        repeat (5) @(posedge clk);
        #1;
        check_value("o_ready in reset", o_ready, 0);
        check_value("o_de in reset", o_de, 0);
        check_value("o_hsync in reset", o_hsync, 1);
        check_value("o_vsync in reset", o_vsync, 1);
        i_rst_n = 1'b1;

        // Empty screen after the reset sweep
        wait_ready();
        check_frame();

        repeat (300) random_pixel();
        idle();
        check_frame();

        // Rising depths only keep the first colour
        for (int i = 0; i < 8; i++) begin
            burst_one_address(i[0]);
        end
        check_frame();

        // Pixels during the sweep are dropped
        pulse_clear();
        repeat (100) random_pixel();
        idle();
        wait_ready();
        check_frame();

        $display("TEST PASSED");
        $finish;
    end

endmodule

/* dv/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock (
    output logic o_clk
);
    // 10 ns period
    localparam int HALF_PERIOD = 5;

    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

endmodule

/* source/display_top.sv */
`timescale 1ns/100ps

module display_top (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_clear,
    input  logic                   i_pix_valid,
    input  display_pkg::pix_addr_t i_pix_addr,
    input  pixel_pkg::color_idx_t  i_pix_color,
    input  pixel_pkg::depth_t      i_pix_depth,
    output logic                   o_ready,
    output pixel_pkg::channel_t    o_red,
    output pixel_pkg::channel_t    o_green,
    output pixel_pkg::channel_t    o_blue,
    output logic                   o_hsync,
    output logic                   o_vsync,
    output logic                   o_de
);
    import display_pkg::*;
    import pixel_pkg::*;

    coord_t     raster_x;
    coord_t     raster_y;
    logic       raster_de;
    logic       raster_hsync;
    logic       raster_vsync;
    pix_addr_t  rd_addr;
    color_idx_t rd_data;

    pixel_write_if pix_wr ();

    raster_timing raster_timing_inst (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .o_x     (raster_x),
        .o_y     (raster_y),
        .o_de    (raster_de),
        .o_hsync (raster_hsync),
        .o_vsync (raster_vsync)
    );

    depth_test depth_test_inst (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_clear     (i_clear),
        .i_pix_valid (i_pix_valid),
        .i_pix_addr  (i_pix_addr),
        .i_pix_color (i_pix_color),
        .i_pix_depth (i_pix_depth),
        .o_ready     (o_ready),
        .fb          (pix_wr.producer)
    );

    frame_buffer frame_buffer_inst (
        .clk       (clk),
        .fb        (pix_wr.consumer),
        .i_rd_addr (rd_addr),
        .o_rd_data (rd_data)
    );

    scan_out scan_out_inst (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_x       (raster_x),
        .i_y       (raster_y),
        .i_de      (raster_de),
        .i_hsync   (raster_hsync),
        .i_vsync   (raster_vsync),
        .o_rd_addr (rd_addr),
        .i_rd_data (rd_data),
        .o_red     (o_red),
        .o_green   (o_green),
        .o_blue    (o_blue),
        .o_de      (o_de),
        .o_hsync   (o_hsync),
        .o_vsync   (o_vsync)
    );

endmodule

/* source/scan_out.sv */
`timescale 1ns/100ps

module scan_out (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  display_pkg::coord_t    i_x,
    input  display_pkg::coord_t    i_y,
    input  logic                   i_de,
    input  logic                   i_hsync,
    input  logic                   i_vsync,
    output display_pkg::pix_addr_t o_rd_addr,
    input  pixel_pkg::color_idx_t  i_rd_data,
    output pixel_pkg::channel_t    o_red,
    output pixel_pkg::channel_t    o_green,
    output pixel_pkg::channel_t    o_blue,
    output logic                   o_de,
    output logic                   o_hsync,
    output logic                   o_vsync
);
    import display_pkg::*;
    import pixel_pkg::*;

    coord_t fb_col;
    coord_t fb_row;
    logic   de_q;
    logic   hsync_q;
    logic   vsync_q;

    // Scale factor is a power of two, so the low bits are dropped
    assign fb_col = i_x >> SCALE_SHIFT;
    assign fb_row = i_y >> SCALE_SHIFT;

    // Blanking reads stay inside the buffer
    assign o_rd_addr = i_de ? pix_addr_t'(fb_row * FB_WIDTH + fb_col) : '0;

    // Stage 1 lines up with the frame buffer read
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            de_q    <= 1'b0;
            hsync_q <= 1'b1;
            vsync_q <= 1'b1;
        end else begin
            de_q    <= i_de;
            hsync_q <= i_hsync;
            vsync_q <= i_vsync;
        end
    end

    // Stage 2 registers the palette colour
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_de                     <= 1'b0;
            o_hsync                  <= 1'b1;
            o_vsync                  <= 1'b1;
            {o_red, o_green, o_blue} <= '0;
        end else begin
            o_de                     <= de_q;
            o_hsync                  <= hsync_q;
            o_vsync                  <= vsync_q;
            {o_red, o_green, o_blue} <= de_q ? palette_lookup(i_rd_data) : rgb_t'(0);
        end
    end

endmodule

/* source/frame_buffer.sv */
`timescale 1ns/100ps

module frame_buffer (
    input  logic                   clk,
    pixel_write_if.consumer        fb,
    input  display_pkg::pix_addr_t i_rd_addr,
    output pixel_pkg::color_idx_t  o_rd_data
);
    import display_pkg::*;
    import pixel_pkg::*;

    color_idx_t color_mem [FB_DEPTH];
    color_idx_t wr_data;
    logic       wr_active;

    // Sweep takes priority over pixel writes
    assign wr_data   = fb.clear_en ? COLOR_CLEAR : fb.wr_color;
    assign wr_active = fb.clear_en || fb.wr_en;

    always_ff @(posedge clk) begin
        if (wr_active) begin
            color_mem[fb.wr_addr] <= wr_data;
        end
    end

    // Registered read port, block RAM style
    always_ff @(posedge clk) begin
        o_rd_data <= color_mem[i_rd_addr];
    end

endmodule

/* source/depth_test.sv */
`timescale 1ns/100ps

module depth_test (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_clear,
    input  logic                   i_pix_valid,
    input  display_pkg::pix_addr_t i_pix_addr,
    input  pixel_pkg::color_idx_t  i_pix_color,
    input  pixel_pkg::depth_t      i_pix_depth,
    output logic                   o_ready,
    pixel_write_if.producer        fb
);
    import display_pkg::*;
    import pixel_pkg::*;

    depth_t     depth_mem [FB_DEPTH];
    depth_t     stored_depth;
    depth_t     cmp_depth;
    logic       pix_valid_q;
    pix_addr_t  pix_addr_q;
    color_idx_t pix_color_q;
    depth_t     pix_depth_q;
    logic       pix_write;
    logic       last_wr_valid;
    pix_addr_t  last_wr_addr;
    depth_t     last_wr_depth;
    logic       clearing;
    pix_addr_t  sweep_addr;

    // stored_depth was read on the same edge as the previous write
    assign cmp_depth = (last_wr_valid && (last_wr_addr == pix_addr_q)) ?
                       last_wr_depth : stored_depth;

    assign pix_write = pix_valid_q && (pix_depth_q < cmp_depth);
    assign o_ready   = !clearing;

    assign fb.wr_en    = pix_write;
    assign fb.clear_en = clearing;
    assign fb.wr_addr  = clearing ? sweep_addr : pix_addr_q;
    assign fb.wr_color = pix_color_q;

    always_ff @(posedge clk) begin
        if (clearing) begin
            depth_mem[sweep_addr] <= DEPTH_CLEAR;
        end else if (pix_write) begin
            depth_mem[pix_addr_q] <= pix_depth_q;
        end
        stored_depth  <= depth_mem[i_pix_addr];
        pix_addr_q    <= i_pix_addr;
        pix_color_q   <= i_pix_color;
        pix_depth_q   <= i_pix_depth;
        last_wr_addr  <= pix_addr_q;
        last_wr_depth <= pix_depth_q;
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pix_valid_q   <= 1'b0;
            last_wr_valid <= 1'b0;
            clearing      <= 1'b1;
            sweep_addr    <= '0;
        end else begin
            // Pixels arriving with a clear pulse are dropped too
            pix_valid_q   <= i_pix_valid && o_ready && !i_clear;
            last_wr_valid <= pix_write;
            if (i_clear) begin
                clearing   <= 1'b1;
                sweep_addr <= '0;
            end else if (clearing) begin
                if (sweep_addr == pix_addr_t'(FB_DEPTH - 1)) begin
                    clearing   <= 1'b0;
                    sweep_addr <= '0;
                end else begin
                    sweep_addr <= sweep_addr + 1'b1;
                end
            end
        end
    end

    a_no_write_during_clear: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        !(fb.wr_en && fb.clear_en)
    ) else $error("pixel write collides with clear sweep");

endmodule

/* source/raster_timing.sv */
`timescale 1ns/100ps

module raster_timing (
    input  logic                clk,
    input  logic                i_rst_n,
    output display_pkg::coord_t o_x,
    output display_pkg::coord_t o_y,
    output logic                o_de,
    output logic                o_hsync,
    output logic                o_vsync
);
    import display_pkg::*;

    coord_t h_cnt;
    coord_t v_cnt;
    logic   line_end;

    assign line_end = (h_cnt == coord_t'(H_TOTAL - 1));

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            if (line_end) begin
                h_cnt <= '0;
                if (v_cnt == coord_t'(V_TOTAL - 1)) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    assign o_x = h_cnt;
    assign o_y = v_cnt;

    assign o_de = (h_cnt < H_ACTIVE) && (v_cnt < V_ACTIVE);

    // Active low syncs
    assign o_hsync = !((h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END));
    assign o_vsync = !((v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END));

    a_counters_in_range: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        (h_cnt < H_TOTAL) && (v_cnt < V_TOTAL)
    ) else $error("raster counters out of range h=%0d v=%0d", h_cnt, v_cnt);

endmodule

/* source/pixel_write_if.sv */
`timescale 1ns/100ps

interface pixel_write_if;
    import display_pkg::*;
    import pixel_pkg::*;

    logic       wr_en;
    pix_addr_t  wr_addr;
    color_idx_t wr_color;
    // High for the whole sweep, wr_addr then walks the buffer
    logic       clear_en;

    modport producer (
        output wr_en, wr_addr, wr_color, clear_en
    );

    modport consumer (
        input wr_en, wr_addr, wr_color, clear_en
    );

endinterface

/* source/pixel_pkg.sv */
package pixel_pkg;

    typedef logic [3:0] color_idx_t;

    // Smaller is nearer
    typedef logic [11:0] depth_t;

    typedef logic [3:0] channel_t;

    // Red in the top bits, then green, then blue
    typedef logic [11:0] rgb_t;

    localparam depth_t     DEPTH_CLEAR = '1;
    localparam color_idx_t COLOR_CLEAR = '0;

    // Fixed palette derived from the index bits
    function automatic rgb_t palette_lookup(input color_idx_t idx);
        channel_t red;
        channel_t green;
        channel_t blue;
        red  = channel_t'(idx);
        blue = channel_t'(~idx);
        for (int i = 0; i < $bits(channel_t); i++) begin
            green[i] = idx[$bits(color_idx_t) - 1 - i];
        end
        return {red, green, blue};
    endfunction

endpackage

/* source/display_pkg.sv */
package display_pkg;

    // Horizontal timing, in pixels
    localparam int unsigned H_ACTIVE = 64;
    localparam int unsigned H_FRONT  = 4;
    localparam int unsigned H_SYNC   = 8;
    localparam int unsigned H_BACK   = 4;
    localparam int unsigned H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

    localparam int unsigned H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam int unsigned H_SYNC_END   = H_SYNC_START + H_SYNC;

    // Vertical timing, in lines
    localparam int unsigned V_ACTIVE = 48;
    localparam int unsigned V_FRONT  = 2;
    localparam int unsigned V_SYNC   = 3;
    localparam int unsigned V_BACK   = 3;
    localparam int unsigned V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    localparam int unsigned V_SYNC_START = V_ACTIVE + V_FRONT;
    localparam int unsigned V_SYNC_END   = V_SYNC_START + V_SYNC;

    // Each buffer pixel covers a 4x4 block on screen
    localparam int unsigned SCALE_SHIFT = 2;

    localparam int unsigned FB_WIDTH  = H_ACTIVE >> SCALE_SHIFT;
    localparam int unsigned FB_HEIGHT = V_ACTIVE >> SCALE_SHIFT;
    localparam int unsigned FB_DEPTH  = FB_WIDTH * FB_HEIGHT;

    // Screen coordinate, wide enough for the totals
    typedef logic [6:0] coord_t;

    // Buffer address, row * FB_WIDTH + column
    typedef logic [7:0] pix_addr_t;

endpackage
